// File: source/mem_cfg_pkg.sv
// Address split, cache geometry and memory timing for the cached memory system.
// Modules refer to these values by package-scoped names.

package mem_cfg_pkg;

   //////////////////////////////
   // Address split
   //////////////////////////////
   localparam int addr_w   = 16;
   localparam int data_w   = 16;
   // Byte address = {tag, index, offset}
   localparam int tag_w    = 5;
   localparam int index_w  = 8;
   localparam int offset_w = 3;

   //////////////////////////////
   // Cache and memory geometry
   //////////////////////////////
   localparam int words_per_line = 4;
   localparam int n_lines        = 256;
   localparam int n_banks        = 4;
   // Word within a line, also the bank number (word address bits 2:1)
   localparam int word_sel_w     = $clog2(words_per_line);
   localparam int bank_sel_w     = $clog2(n_banks);
   // One line maps to one row across all banks
   localparam int row_w          = addr_w - offset_w;
   localparam int bank_depth     = 2 ** row_w;

   // Memory timing in clock cycles
   localparam int mem_latency      = 2;
   localparam int bank_busy_cycles = 4;
   localparam int busy_w           = $clog2(bank_busy_cycles);

endpackage

// File: source/mem_types_pkg.sv
// Packed structs passed between the cache controller, the cache array
// and the banked main memory.

package mem_types_pkg;

   // One data word, the payload of the data store and the memory banks
   typedef logic [mem_cfg_pkg::data_w-1:0] word_t;

   // Tag store entry, one per cache line
   typedef struct packed {
      logic [mem_cfg_pkg::tag_w-1:0] tag;
      logic                          valid;
      logic                          dirty;
   } line_state_t;

   //////////////////////////////
   // Controller and cache array
   //////////////////////////////
   typedef struct packed {
      logic                             en;
      logic                             comp;
      logic                             write;
      logic [mem_cfg_pkg::index_w-1:0]  index;
      logic [mem_cfg_pkg::offset_w-1:0] offset;
      logic [mem_cfg_pkg::tag_w-1:0]    tag;
      word_t                            wdata;
   } cache_req_t;

   typedef struct packed {
      logic                          hit;
      logic                          victim_dirty;
      // Stored tag, used to rebuild the victim address
      logic [mem_cfg_pkg::tag_w-1:0] tag;
      word_t                         rdata;
   } cache_rsp_t;

   //////////////////////////////
   // Controller and main memory
   //////////////////////////////
   typedef struct packed {
      logic                           rd;
      logic                           wr;
      logic [mem_cfg_pkg::addr_w-1:0] addr;
      word_t                          wdata;
   } mem_req_t;

   typedef struct packed {
      word_t rdata;
      logic  stall;
   } mem_rsp_t;

endpackage

// File: source/sync_ram.sv
// Single-port storage array, synchronous write and combinational read.
// The entry type is a parameter; clear_on_reset zeroes the array on rst_n.
`timescale 1ns/1ps

module sync_ram #(
   parameter type entry_t        = logic [15:0],
   parameter int  depth          = 256,
   parameter bit  clear_on_reset = 1'b0
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     we,
   input  logic [$clog2(depth)-1:0] waddr,
   input  entry_t                   wdata,
   input  logic [$clog2(depth)-1:0] raddr,
   output entry_t                   rdata
);

   entry_t mem [depth];

   // Write port
   // Only the line state store is cleared, so all lines start invalid
   always_ff @(posedge clk) begin
      if (clear_on_reset && !rst_n) begin
         for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Read port, same cycle
   assign rdata = mem[raddr];

endmodule

// File: source/cache_array.sv
// Direct-mapped cache storage: line state store and data word store.
// Does the tag compare, reports the victim line and applies the
// compare-write and fill-write rules for the controller.
`timescale 1ns/1ps

module cache_array (
   input  logic                      clk,
   input  logic                      rst_n,
   input  mem_types_pkg::cache_req_t req,
   output mem_types_pkg::cache_rsp_t rsp
);

   localparam int data_depth = mem_cfg_pkg::n_lines * mem_cfg_pkg::words_per_line;

   mem_types_pkg::line_state_t line_rd;
   mem_types_pkg::line_state_t line_wr;
   mem_types_pkg::word_t       data_rd;
   logic                       line_we;
   logic                       data_we;
   logic                       tag_match;
   logic [$clog2(data_depth)-1:0] data_addr;

   // Data word address is {index, word in line}
   // Byte bit of the offset is ignored, accesses are word aligned
   assign data_addr = {req.index,
                       req.offset[mem_cfg_pkg::offset_w-1 -: mem_cfg_pkg::word_sel_w]};

   //////////////////////////////
   // Tag compare and response
   //////////////////////////////
   assign tag_match        = line_rd.valid && (line_rd.tag == req.tag);
   assign rsp.hit          = req.en && tag_match;
   // Victim needs write-back only when the miss lands on a dirty valid line
   assign rsp.victim_dirty = req.en && !tag_match && line_rd.valid && line_rd.dirty;
   assign rsp.tag          = line_rd.tag;
   assign rsp.rdata        = data_rd;

   //////////////////////////////
   // Write rules
   //////////////////////////////
   always_comb begin
      line_we = 1'b0;
      data_we = 1'b0;
      line_wr = line_rd;
      if (req.en && req.write) begin
         if (req.comp) begin
            // CPU write, only on a hit; line becomes dirty
            if (tag_match) begin
               line_we       = 1'b1;
               data_we       = 1'b1;
               line_wr.dirty = 1'b1;
            end
         end else begin
            // Line fill from memory, clean line with new tag
            line_we       = 1'b1;
            data_we       = 1'b1;
            line_wr.tag   = req.tag;
            line_wr.valid = 1'b1;
            line_wr.dirty = 1'b0;
         end
      end
   end

   // Tag, valid and dirty per line
   sync_ram #(
      .entry_t        (mem_types_pkg::line_state_t),
      .depth          (mem_cfg_pkg::n_lines),
      .clear_on_reset (1'b1)
   ) i_line_store (
      .clk   (clk),
      .rst_n (rst_n),
      .we    (line_we),
      .waddr (req.index),
      .wdata (line_wr),
      .raddr (req.index),
      .rdata (line_rd)
   );

   // Data words, four per line
   sync_ram #(
      .entry_t (mem_types_pkg::word_t),
      .depth   (data_depth)
   ) i_data_store (
      .clk   (clk),
      .rst_n (rst_n),
      .we    (data_we),
      .waddr (data_addr),
      .wdata (req.wdata),
      .raddr (data_addr),
      .rdata (data_rd)
   );

endmodule

// File: source/banked_mem.sv
// Four-bank main memory behind the cache. Reads return after a fixed latency;
// each bank stays busy for a few cycles after an access and raises stall.
`timescale 1ns/1ps

module banked_mem (
   input  logic                    clk,
   input  logic                    rst_n,
   input  mem_types_pkg::mem_req_t req,
   output mem_types_pkg::mem_rsp_t rsp
);

   logic [mem_cfg_pkg::bank_sel_w-1:0] bank_sel;
   logic [mem_cfg_pkg::row_w-1:0]      row;
   logic                               accept;
   mem_types_pkg::word_t               bank_rdata [mem_cfg_pkg::n_banks];
   logic [mem_cfg_pkg::busy_w-1:0]     busy_cnt [mem_cfg_pkg::n_banks];
   mem_types_pkg::word_t               rd_pipe [mem_cfg_pkg::mem_latency];

   //////////////////////////////
   // Address decode
   //////////////////////////////
   // Bank from word address bits 2:1, so words of one line hit all banks
   assign bank_sel = req.addr[1 +: mem_cfg_pkg::bank_sel_w];
   assign row      = req.addr[mem_cfg_pkg::addr_w-1 -: mem_cfg_pkg::row_w];

   // Stall follows the addressed bank, independent of the strobes
   assign rsp.stall = (busy_cnt[bank_sel] != '0);
   assign accept    = (req.rd || req.wr) && !rsp.stall;

   //////////////////////////////
   // Banks and busy counters
   //////////////////////////////
   for (genvar b = 0; b < mem_cfg_pkg::n_banks; b++) begin : g_bank
      sync_ram #(
         .entry_t (mem_types_pkg::word_t),
         .depth   (mem_cfg_pkg::bank_depth)
      ) i_bank (
         .clk   (clk),
         .rst_n (rst_n),
         .we    (accept && req.wr && (bank_sel == mem_cfg_pkg::bank_sel_w'(b))),
         .waddr (row),
         .wdata (req.wdata),
         .raddr (row),
         .rdata (bank_rdata[b])
      );

      // Busy for bank_busy_cycles counting the access cycle itself
      always_ff @(posedge clk) begin
         if (!rst_n) begin
            busy_cnt[b] <= '0;
         end else if (accept && (bank_sel == mem_cfg_pkg::bank_sel_w'(b))) begin
            busy_cnt[b] <= mem_cfg_pkg::busy_w'(mem_cfg_pkg::bank_busy_cycles - 1);
         end else if (busy_cnt[b] != '0) begin
            busy_cnt[b] <= busy_cnt[b] - 1'b1;
         end
      end
   end

   //////////////////////////////
   // Read latency pipeline
   //////////////////////////////
   // One stage per latency cycle, several reads can be in flight
   always_ff @(posedge clk) begin
      rd_pipe[0] <= (accept && req.rd) ? bank_rdata[bank_sel] : '0;
      for (int s = 1; s < mem_cfg_pkg::mem_latency; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   assign rsp.rdata = rd_pipe[mem_cfg_pkg::mem_latency-1];

endmodule

// File: source/cache_ctrl.sv
// Cache controller FSM. Accepts CPU word reads and writes, checks the cache,
// writes back a dirty victim, fills the line from memory and completes.
// Drives the cache array and the banked memory request structs.
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                             clk,
   input  logic                             rst_n,
   // CPU side
   input  logic [mem_cfg_pkg::addr_w-1:0]   addr,
   input  logic [mem_cfg_pkg::data_w-1:0]   data_in,
   input  logic                             rd,
   input  logic                             wr,
   output logic [mem_cfg_pkg::data_w-1:0]   data_out,
   output logic                             done,
   output logic                             stall,
   output logic                             cache_hit,
   // Cache array
   output mem_types_pkg::cache_req_t        creq,
   input  mem_types_pkg::cache_rsp_t        crsp,
   // Main memory
   output mem_types_pkg::mem_req_t          mreq,
   input  mem_types_pkg::mem_rsp_t          mrsp
);

   // s_compare serves both the compare read and the compare write
   typedef enum logic [2:0] {
      s_idle,
      s_compare,
      s_hit_ret,
      s_wr_back,
      s_fill,
      s_miss_rd_ret,
      s_miss_wr
   } state_t;

   state_t state;
   state_t state_nxt;

   // Request latched at acceptance
   logic [mem_cfg_pkg::addr_w-1:0]   req_addr;
   logic [mem_cfg_pkg::data_w-1:0]   req_data;
   logic                             req_wr;
   logic [mem_cfg_pkg::tag_w-1:0]    req_tag;
   logic [mem_cfg_pkg::index_w-1:0]  req_index;
   logic [mem_cfg_pkg::offset_w-1:0] req_offset;

   // Memory issue counter, extra bit marks all four fill reads issued
   logic [mem_cfg_pkg::word_sel_w:0]   word_cnt;
   logic [mem_cfg_pkg::word_sel_w:0]   word_cnt_nxt;
   // Returned fill words
   logic [mem_cfg_pkg::word_sel_w-1:0] fill_cnt;
   logic [mem_cfg_pkg::word_sel_w-1:0] fill_cnt_nxt;
   // Outstanding fill reads, one bit per latency cycle
   logic [mem_cfg_pkg::mem_latency-1:0] rd_pend;
   logic                                fill_ret;

   logic accept;

   assign accept     = (state == s_idle) && (rd || wr);
   assign req_tag    = req_addr[mem_cfg_pkg::addr_w-1 -: mem_cfg_pkg::tag_w];
   assign req_index  = req_addr[mem_cfg_pkg::offset_w +: mem_cfg_pkg::index_w];
   assign req_offset = req_addr[mem_cfg_pkg::offset_w-1:0];
   assign fill_ret   = rd_pend[mem_cfg_pkg::mem_latency-1];

   // Busy in every state but idle, so stall drops the cycle after done
   assign stall = (state != s_idle);

   //////////////////////////////
   // Next state and outputs
   //////////////////////////////
   always_comb begin
      state_nxt    = state;
      word_cnt_nxt = word_cnt;
      fill_cnt_nxt = fill_cnt;
      data_out     = '0;
      done         = 1'b0;
      cache_hit    = 1'b0;
      // Cache points at the latched request by default
      creq         = '0;
      creq.index   = req_index;
      creq.offset  = req_offset;
      creq.tag     = req_tag;
      creq.wdata   = req_data;
      mreq         = '0;

      case (state)
         s_idle: begin
            if (accept) begin
               state_nxt = s_compare;
            end
         end

         s_compare: begin
            creq.en      = 1'b1;
            creq.comp    = 1'b1;
            creq.write   = req_wr;
            word_cnt_nxt = '0;
            fill_cnt_nxt = '0;
            if (crsp.hit) begin
               if (req_wr) begin
                  // Write hit finishes here
                  done      = 1'b1;
                  cache_hit = 1'b1;
                  state_nxt = s_idle;
               end else begin
                  state_nxt = s_hit_ret;
               end
            end else if (crsp.victim_dirty) begin
               state_nxt = s_wr_back;
            end else begin
               state_nxt = s_fill;
            end
         end

         s_hit_ret: begin
            creq.en   = 1'b1;
            creq.comp = 1'b1;
            data_out  = crsp.rdata;
            done      = 1'b1;
            cache_hit = 1'b1;
            state_nxt = s_idle;
         end

         // Victim words go out in order, address from the stored tag
         s_wr_back: begin
            creq.en     = 1'b1;
            creq.offset = {word_cnt[mem_cfg_pkg::word_sel_w-1:0], 1'b0};
            mreq.addr   = {crsp.tag, req_index, word_cnt[mem_cfg_pkg::word_sel_w-1:0], 1'b0};
            mreq.wdata  = crsp.rdata;
            mreq.wr     = !mrsp.stall;
            if (!mrsp.stall) begin
               if (word_cnt == mem_cfg_pkg::words_per_line - 1) begin
                  word_cnt_nxt = '0;
                  state_nxt    = s_fill;
               end else begin
                  word_cnt_nxt = word_cnt + 1'b1;
               end
            end
         end

         s_fill: begin
            // Read side
            mreq.addr = {req_tag, req_index, word_cnt[mem_cfg_pkg::word_sel_w-1:0], 1'b0};
            if (!word_cnt[mem_cfg_pkg::word_sel_w] && !mrsp.stall) begin
               mreq.rd      = 1'b1;
               word_cnt_nxt = word_cnt + 1'b1;
            end
            // Return side, mem_latency cycles behind
            if (fill_ret) begin
               creq.en      = 1'b1;
               creq.write   = 1'b1;
               creq.offset  = {fill_cnt, 1'b0};
               creq.wdata   = mrsp.rdata;
               fill_cnt_nxt = fill_cnt + 1'b1;
               if (fill_cnt == mem_cfg_pkg::words_per_line - 1) begin
                  state_nxt = req_wr ? s_miss_wr : s_miss_rd_ret;
               end
            end
         end

         // Line is present now; the reply still counts as a miss
         s_miss_rd_ret: begin
            creq.en   = 1'b1;
            creq.comp = 1'b1;
            data_out  = crsp.rdata;
            done      = 1'b1;
            state_nxt = s_idle;
         end

         s_miss_wr: begin
            creq.en    = 1'b1;
            creq.comp  = 1'b1;
            creq.write = 1'b1;
            done       = 1'b1;
            state_nxt  = s_idle;
         end

         default: begin
            state_nxt = s_idle;
         end
      endcase
   end

   //////////////////////////////
   // Registers
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= s_idle;
         word_cnt <= '0;
         fill_cnt <= '0;
         rd_pend  <= '0;
      end else begin
         state    <= state_nxt;
         word_cnt <= word_cnt_nxt;
         fill_cnt <= fill_cnt_nxt;
         rd_pend  <= (rd_pend << 1) | mem_cfg_pkg::mem_latency'(mreq.rd);
      end
   end

   // CPU request capture
   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
   end

endmodule

// File: source/mem_system.sv
// Top level of the cached memory system. The controller sits between the
// CPU ports, the cache array and the four-bank main memory.
`timescale 1ns/1ps

module mem_system (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mem_cfg_pkg::addr_w-1:0] addr,
   input  logic [mem_cfg_pkg::data_w-1:0] data_in,
   input  logic                           rd,
   input  logic                           wr,
   output logic [mem_cfg_pkg::data_w-1:0] data_out,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit
);

   mem_types_pkg::cache_req_t creq;
   mem_types_pkg::cache_rsp_t crsp;
   mem_types_pkg::mem_req_t   mreq;
   mem_types_pkg::mem_rsp_t   mrsp;

   cache_ctrl i_cache_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .creq      (creq),
      .crsp      (crsp),
      .mreq      (mreq),
      .mrsp      (mrsp)
   );

   cache_array i_cache_array (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (creq),
      .rsp   (crsp)
   );

   banked_mem i_banked_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (mreq),
      .rsp   (mrsp)
   );

endmodule

// File: sim/mem_system_checker.sv
// Watches the CPU ports of the cached memory system and predicts every reply.
// Keeps a word model and a direct-mapped tag model, compares on each done pulse.
`timescale 1ns/1ps

module mem_system_checker (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mem_cfg_pkg::addr_w-1:0] addr,
   input  logic [mem_cfg_pkg::data_w-1:0] data_in,
   input  logic                           rd,
   input  logic                           wr,
   input  logic [mem_cfg_pkg::data_w-1:0] data_out,
   input  logic                           done,
   input  logic                           stall,
   input  logic                           cache_hit,
   output int                             error_count,
   output int                             accept_count,
   output int                             done_count
);

   // One accepted request with its predicted reply
   typedef struct packed {
      logic                           wr;
      logic [mem_cfg_pkg::addr_w-1:0] addr;
      logic                           hit;
      logic [mem_cfg_pkg::data_w-1:0] data;
      logic [31:0]                    cycle;
   } expect_t;

   // Words written so far by word address
   logic [mem_cfg_pkg::data_w-1:0] word_model [logic [mem_cfg_pkg::addr_w-1:0]];
   // Which tag each line holds
   logic [mem_cfg_pkg::tag_w-1:0]  tag_model [mem_cfg_pkg::n_lines];
   logic                           valid_model [mem_cfg_pkg::n_lines];
   expect_t                        pending [$];
   logic [31:0]                    cycle = '0;
   logic                           out_of_reset = 1'b0;
   // Request accepted and its done not yet seen
   logic                           in_flight = 1'b0;
   int                             errors = 0;
   int                             accepts = 0;
   int                             dones = 0;

   assign error_count  = errors;
   assign accept_count = accepts;
   assign done_count   = dones;

   // Cycle counter that the other processes read before it advances
   always @(negedge clk) begin
      cycle <= cycle + 1;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////
   function automatic expect_t predict(input logic                           is_wr,
                                       input logic [mem_cfg_pkg::addr_w-1:0] a,
                                       input logic [mem_cfg_pkg::data_w-1:0] d,
                                       input logic [31:0]                    cyc);
      expect_t                         e;
      logic [mem_cfg_pkg::index_w-1:0] idx;
      logic [mem_cfg_pkg::tag_w-1:0]   tg;
      logic [mem_cfg_pkg::addr_w-1:0]  word_addr;
      // Byte address is {tag, index, offset}
      idx       = a[mem_cfg_pkg::offset_w +: mem_cfg_pkg::index_w];
      tg        = a[mem_cfg_pkg::addr_w-1 -: mem_cfg_pkg::tag_w];
      word_addr = {a[mem_cfg_pkg::addr_w-1:1], 1'b0};
      e.wr      = is_wr;
      e.addr    = a;
      e.cycle   = cyc;
      e.hit     = valid_model[idx] && (tag_model[idx] == tg);
      if (is_wr) begin
         word_model[word_addr] = d;
         e.data = d;
      end else if (word_model.exists(word_addr)) begin
         e.data = word_model[word_addr];
      end else begin
         e.data = 'x;
      end
      // Every access leaves its line resident under write-allocate
      valid_model[idx] = 1'b1;
      tag_model[idx]   = tg;
      return e;
   endfunction

   task automatic check_value(input string                          name,
                              input logic [mem_cfg_pkg::data_w-1:0] got,
                              input logic [mem_cfg_pkg::data_w-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // Request taken when rd or wr is high while stall is low
   always @(negedge clk) begin : record_accept
      if (!rst_n) begin
         for (int i = 0; i < mem_cfg_pkg::n_lines; i++) begin
            valid_model[i] = 1'b0;
         end
      end else if ((rd || wr) && (stall === 1'b0)) begin
         pending.push_back(predict(wr, addr, data_in, cycle));
         accepts++;
      end
   end

   //////////////////////////////
   // Compare on done
   //////////////////////////////
   always @(negedge clk) begin : compare_on_done
      expect_t exp_rsp;
      int      latency;
      if (rst_n) begin
         // Stall is high from the cycle after acceptance through the done cycle
         check_value("stall", stall, in_flight);
         if (!out_of_reset) begin
            // Outputs stay quiet in the first cycle after reset
            out_of_reset = 1'b1;
            check_value("done", done, 1'b0);
            check_value("cache_hit", cache_hit, 1'b0);
         end else if (done === 1'b1) begin
            dones++;
            if (pending.size() == 0) begin
               errors++;
               $display("done pulse at %0t without an accepted request", $time);
            end else begin
               exp_rsp = pending.pop_front();
               check_value("cache_hit", cache_hit, exp_rsp.hit);
               if (!exp_rsp.wr) begin
                  check_value("data_out", data_out, exp_rsp.data);
               end
               // Write hit ends one cycle after acceptance, read hit two
               if (exp_rsp.hit) begin
                  latency = int'(cycle - exp_rsp.cycle);
                  if (latency != (exp_rsp.wr ? 1 : 2)) begin
                     errors++;
                     $display("Hit to address %h at %0t took %0d cycles, expected %0d",
                              exp_rsp.addr, $time, latency, exp_rsp.wr ? 1 : 2);
                  end
               end
            end
         end
         if (done === 1'b1) begin
            in_flight = 1'b0;
         end else if ((rd || wr) && (stall === 1'b0)) begin
            in_flight = 1'b1;
         end
      end
   end

endmodule

// File: sim/tb_mem_system.sv
// Testbench for the cached memory system. Drives directed and seeded random
// word reads and writes; mem_system_checker predicts and compares the replies.
`timescale 1ns/1ps

module tb_mem_system;

   localparam int wait_limit = 64;

   // One CPU request as driven on the ports
   typedef struct packed {
      logic                           wr;
      logic [mem_cfg_pkg::addr_w-1:0] addr;
      logic [mem_cfg_pkg::data_w-1:0] data;
   } cpu_req_t;

   logic                           clk;
   logic                           rst_n;
   logic [mem_cfg_pkg::addr_w-1:0] addr;
   logic [mem_cfg_pkg::data_w-1:0] data_in;
   logic                           rd;
   logic                           wr;
   logic [mem_cfg_pkg::data_w-1:0] data_out;
   logic                           done;
   logic                           stall;
   logic                           cache_hit;
   int                             error_count;
   int                             accept_count;
   int                             done_count;
   int                             timeout_count = 0;
   bit                             pool_written [32];

   // 8 ns clock
   always #4 clk = ~clk;

   mem_system i_mem_system (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit)
   );

   mem_system_checker i_mem_system_checker (
      .clk          (clk),
      .rst_n        (rst_n),
      .addr         (addr),
      .data_in      (data_in),
      .rd           (rd),
      .wr           (wr),
      .data_out     (data_out),
      .done         (done),
      .stall        (stall),
      .cache_hit    (cache_hit),
      .error_count  (error_count),
      .accept_count (accept_count),
      .done_count   (done_count)
   );

   //////////////////////////////
   // Request tasks
   //////////////////////////////
   // All waits step one clock at a time and sample 1 ns after the edge
   task automatic wait_not_stalled();
      int waited;
      waited = 0;
      while ((stall !== 1'b0) && (waited < wait_limit)) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (stall !== 1'b0) begin
         timeout_count++;
         $display("Timeout at %0t: stall stayed high for %0d cycles", $time, wait_limit);
      end
   endtask

   task automatic wait_done(input cpu_req_t req);
      int waited;
      waited = 0;
      while ((done !== 1'b1) && (waited < wait_limit)) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (done !== 1'b1) begin
         timeout_count++;
         $display("Timeout at %0t: no done for access to %h within %0d cycles",
                  $time, req.addr, wait_limit);
      end
   endtask

   // Nothing more is driven once a wait has timed out
   task automatic issue_request(input cpu_req_t req);
      if (timeout_count == 0) begin
         wait_not_stalled();
      end
      if (timeout_count == 0) begin
         addr    = req.addr;
         data_in = req.data;
         rd      = !req.wr;
         wr      = req.wr;
         @(posedge clk);
         #1;
         rd = 1'b0;
         wr = 1'b0;
         wait_done(req);
      end
   endtask

   task automatic write_word(input logic [15:0] a, input logic [15:0] d);
      cpu_req_t req;
      req.wr   = 1'b1;
      req.addr = a;
      req.data = d;
      issue_request(req);
   endtask

   task automatic read_word(input logic [15:0] a);
      cpu_req_t req;
      req.wr   = 1'b0;
      req.addr = a;
      req.data = '0;
      issue_request(req);
   endtask

   // Random pool of four tags over two neighbouring lines with four words each
   function automatic logic [15:0] pool_addr(input int p);
      logic [mem_cfg_pkg::tag_w-1:0]   tg;
      logic [mem_cfg_pkg::index_w-1:0] idx;
      logic [1:0]                      w;
      tg  = mem_cfg_pkg::tag_w'(p / 8);
      idx = mem_cfg_pkg::index_w'(8'h10 + (p / 4) % 2);
      w   = 2'(p % 4);
      return {tg, idx, w, 1'b0};
   endfunction

   initial begin
      int p;
      int total_errors;
      clk     = 1'b0;
      rst_n   = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      void'($urandom(32'hc141bd0b));
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;

      //////////////////////////////
      // Directed cases
      //////////////////////////////
      // First write misses, read back hits
      write_word(16'h0040, 16'h1234);
      read_word(16'h0040);

      // Tags 1 and 2 share index 1 and each read evicts the dirty other line
      write_word(16'h0808, 16'ha001);
      write_word(16'h1008, 16'hb001);
      for (int r = 0; r < 2; r++) begin
         read_word(16'h0808);
         write_word(16'h0808, 16'ha100 + 16'(r));
         read_word(16'h1008);
         write_word(16'h1008, 16'hb100 + 16'(r));
      end

      // Full line is evicted by tag 3 and read back through a fill
      for (int w = 0; w < 4; w++) begin
         write_word(16'h0120 + 16'(2 * w), 16'hc0de + 16'(w));
      end
      write_word(16'h1920, 16'h5a5a);
      for (int w = 0; w < 4; w++) begin
         read_word(16'h0120 + 16'(2 * w));
      end

      // Random mix that reads only words already written
      for (int n = 0; n < 400; n++) begin
         p = int'($urandom % 32);
         if (!pool_written[p] || ($urandom % 2 == 0)) begin
            write_word(pool_addr(p), 16'($urandom));
            pool_written[p] = 1'b1;
         end else begin
            read_word(pool_addr(p));
         end
      end

      // Let the checker see the last done
      repeat (4) @(posedge clk);
      total_errors = error_count;
      if (accept_count != done_count) begin
         total_errors++;
         $display("%0d requests accepted but %0d done pulses seen", accept_count, done_count);
      end
      $display("Closing report: %0d errors, %0d timeouts", total_errors, timeout_count);
      if ((total_errors == 0) && (timeout_count == 0)) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: sim.f
source/mem_cfg_pkg.sv
source/mem_types_pkg.sv
source/sync_ram.sv
source/cache_array.sv
source/banked_mem.sv
source/cache_ctrl.sv
source/mem_system.sv
sim/mem_system_checker.sv
sim/tb_mem_system.sv
